//--- Bender.yml
package:
  name: afu_dma

sources:
  - files:
      - common/dma_pkg.sv
      - common/avmm_if.sv
      - common/dma_cmd_if.sv
      - dma/dma_fifo.sv
      - dma/dma_ctrl.sv
      - dma/dma_read_master.sv
      - dma/dma_write_master.sv
      - rtl/mmio_bridge.sv
      - rtl/bank_switch.sv
      - rtl/afu.sv
  - target: test
    files:
      - testbench/tb_avmm_mem.sv
      - testbench/tb_afu.sv

//--- common/avmm_if.sv
/* single-word Avalon-MM, no burstcount and no byteenable
   read data comes back in order and cannot be stalled */
`timescale 1ns/1ns

interface avmm_if #(
	parameter int mem_addr_width = 12
);
	import dma_pkg::*;

	logic [mem_addr_width-1:0] address; // word address
	logic read;
	logic write;
	t_word writedata;
	logic waitrequest; // command held while high
	t_word readdata;
	logic readdatavalid;

	modport master (
		output address, read, write, writedata,
		input waitrequest, readdata, readdatavalid
	);

	modport slave (
		input address, read, write, writedata,
		output waitrequest, readdata, readdatavalid
	);

endinterface

//--- common/dma_cmd_if.sv
/* job command from the controller to one engine
   finished is a level, set after the last word and cleared by the next go */
`timescale 1ns/1ns

interface dma_cmd_if #(
	parameter int mem_addr_width = 12
);
	logic go; // single cycle
	logic [mem_addr_width-1:0] base; // first word address
	logic [mem_addr_width:0] count; // one extra bit, full bank fits
	logic finished;

	// controller side
	modport ctrl (output go, base, count, input finished);

	// read or write engine side
	modport engine (input go, base, count, output finished);

endinterface

//--- common/dma_pkg.sv
/* widths, register map and mmio request layout for the copy engine
   registers decode on the full byte address, so only aligned 64-bit accesses hit */
package dma_pkg;

	// ********************
	// widths
	localparam int mmio_addr_width = 18;
	localparam int mmio_data_width = 64;
	localparam int word_width = 64; // one bank word, no byte enables

	typedef logic [word_width-1:0] t_word;

	// host request, msb first: wr, rd, addr, data (84 bits)
	typedef struct packed {
		logic wr;
		logic rd;
		logic [mmio_addr_width-1:0] addr;
		logic [mmio_data_width-1:0] data;
	} t_mmio_req;

	// ********************
	// register map, byte offsets
	localparam logic [mmio_addr_width-1:0] reg_src = 18'h00; // source word address
	localparam logic [mmio_addr_width-1:0] reg_dst = 18'h08; // destination word address
	localparam logic [mmio_addr_width-1:0] reg_len = 18'h10; // length in words
	localparam logic [mmio_addr_width-1:0] reg_ctrl = 18'h18;
	localparam logic [mmio_addr_width-1:0] reg_status = 18'h20;

	// ctrl bits
	localparam int ctrl_start_bit = 0; // write 1 to launch, reads back 0
	localparam int ctrl_dir_bit = 1; // 0: a to b, 1: b to a

	// status bits
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1; // sticky until next start

endpackage

//--- dma/dma_ctrl.sv
/* src, dst and len writes are ignored while busy, as are start writes
   length zero finishes one cycle after start with no memory access */
`timescale 1ns/1ns

module dma_ctrl #(
	parameter int mem_addr_width = 12
) (
	input logic clk,
	input logic reset,
	input logic reg_wr,
	input logic reg_rd,
	input logic [dma_pkg::mmio_addr_width-1:0] reg_addr,
	input logic [dma_pkg::mmio_data_width-1:0] reg_wdata,
	output logic [dma_pkg::mmio_data_width-1:0] reg_rdata,
	output logic dir,
	dma_cmd_if.ctrl rd_cmd,
	dma_cmd_if.ctrl wr_cmd
);
	import dma_pkg::*;

	logic [mem_addr_width-1:0] src;
	logic [mem_addr_width-1:0] dst;
	logic [mem_addr_width:0] len;
	logic busy;
	logic done;
	logic go;
	logic start;
	logic cfg_wr; // config write that is allowed to land
	logic [mmio_data_width-1:0] rdata;

	assign cfg_wr = reg_wr && !busy;
	assign start = cfg_wr && (reg_addr == reg_ctrl) && reg_wdata[ctrl_start_bit];

	// ********************
	// config registers
	always_ff @(posedge clk) begin
		if (reset) begin
			src <= '0;
			dst <= '0;
			len <= '0;
			dir <= 1'b0;
		end else if (cfg_wr) begin
			case (reg_addr)
				reg_src: src <= reg_wdata[mem_addr_width-1:0];
				reg_dst: dst <= reg_wdata[mem_addr_width-1:0];
				reg_len: len <= reg_wdata[mem_addr_width:0];
				reg_ctrl: dir <= reg_wdata[ctrl_dir_bit]; // same write as start
				default: ;
			endcase
		end
	end

	// ********************
	// job sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			go <= 1'b0;
		end else begin
			go <= start; // engines launch next edge
			if (start) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (busy && go && len == '0) begin
				busy <= 1'b0; // nothing to move
				done <= 1'b1;
			end else if (busy && !go && wr_cmd.finished && rd_cmd.finished) begin
				busy <= 1'b0; // finished still shows the last job during go
				done <= 1'b1;
			end
		end
	end

	assign rd_cmd.go = go;
	assign rd_cmd.base = src;
	assign rd_cmd.count = len;
	assign wr_cmd.go = go;
	assign wr_cmd.base = dst;
	assign wr_cmd.count = len;

	// unmapped offsets read as 0
	always_comb begin
		rdata = '0;
		case (reg_addr)
			reg_src: rdata[mem_addr_width-1:0] = src;
			reg_dst: rdata[mem_addr_width-1:0] = dst;
			reg_len: rdata[mem_addr_width:0] = len;
			reg_ctrl: rdata[ctrl_dir_bit] = dir; // start bit reads 0
			reg_status: begin
				rdata[status_busy_bit] = busy;
				rdata[status_done_bit] = done;
			end
			default: ;
		endcase
	end
	assign reg_rdata = reg_rd ? rdata : '0;

	// write side cannot close before every word was read
	a_read_ends_first : assert property (@(posedge clk) disable iff (reset)
		wr_cmd.finished |-> rd_cmd.finished);

endmodule

//--- dma/dma_fifo.sv
/* show-ahead FIFO, pop_data is the head whenever not empty
   push when full or pop when empty is illegal */
`timescale 1ns/1ns

module dma_fifo #(
	parameter type t_payload = dma_pkg::t_word,
	parameter int depth = 8
) (
	input logic clk,
	input logic reset,
	input logic push,
	input t_payload push_data,
	input logic pop,
	output t_payload pop_data,
	output logic empty,
	output logic full,
	output logic [$clog2(depth+1)-1:0] count
);

	localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
	localparam logic [ptr_width-1:0] last_ptr = ptr_width'(depth - 1);

	t_payload mem [depth]; // storage, no reset
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1; // wrap any depth
			if (pop) rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
		if (push) mem[wr_ptr] <= push_data;

	assign pop_data = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == ($clog2(depth+1))'(depth));

	a_no_overflow : assert property (@(posedge clk) disable iff (reset) !(push && full));
	a_no_underflow : assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

//--- dma/dma_read_master.sv
/* reads in flight plus words already in the FIFO never exceed fifo_depth
   addresses wrap at the end of the bank */
`timescale 1ns/1ns

module dma_read_master #(
	parameter int mem_addr_width = 12,
	parameter int fifo_depth = 8
) (
	input logic clk,
	input logic reset,
	input logic [$clog2(fifo_depth+1)-1:0] fifo_count,
	output logic push,
	output dma_pkg::t_word push_data,
	dma_cmd_if.engine cmd,
	avmm_if.master mem
);

	logic active;
	logic [mem_addr_width:0] issued; // reads accepted
	logic [mem_addr_width:0] returned; // words pushed
	logic [$clog2(fifo_depth+1)-1:0] outstanding;
	logic credit_ok;
	logic rd_accept;

	// sum cannot grow while a read waits, so the command holds
	assign credit_ok = (outstanding + fifo_count) < fifo_depth;
	assign mem.read = active && (issued != cmd.count) && credit_ok;
	assign mem.address = cmd.base + issued[mem_addr_width-1:0];
	assign mem.write = 1'b0;
	assign mem.writedata = '0;
	assign rd_accept = mem.read && !mem.waitrequest;

	assign push = mem.readdatavalid; // no stall on return path
	assign push_data = mem.readdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			issued <= '0;
			returned <= '0;
			outstanding <= '0;
			cmd.finished <= 1'b0;
		end else if (cmd.go) begin
			active <= 1'b1;
			issued <= '0;
			returned <= '0;
			cmd.finished <= 1'b0;
		end else begin
			if (rd_accept) issued <= issued + 1'b1;
			if (push) returned <= returned + 1'b1;
			case ({rd_accept, push})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: ;
			endcase
			if (active && returned == cmd.count) begin
				active <= 1'b0; // last word landed in the FIFO
				cmd.finished <= 1'b1;
			end
		end
	end

	a_addr_hold : assert property (@(posedge clk) disable iff (reset)
		mem.read && mem.waitrequest |=> mem.read && $stable(mem.address));

endmodule

//--- dma/dma_write_master.sv
/* writes the FIFO head straight out, pop only on acceptance
   stalls on an empty FIFO or on waitrequest */
`timescale 1ns/1ns

module dma_write_master #(
	parameter int mem_addr_width = 12
) (
	input logic clk,
	input logic reset,
	input logic fifo_empty,
	input dma_pkg::t_word pop_data,
	output logic pop,
	dma_cmd_if.engine cmd,
	avmm_if.master mem
);

	logic active;
	logic [mem_addr_width:0] written; // writes accepted

	// head and empty only change on pop, so command holds under wait
	assign mem.write = active && !fifo_empty && (written != cmd.count);
	assign mem.address = cmd.base + written[mem_addr_width-1:0];
	assign mem.writedata = pop_data;
	assign mem.read = 1'b0;
	assign pop = mem.write && !mem.waitrequest;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			written <= '0;
			cmd.finished <= 1'b0;
		end else if (cmd.go) begin
			active <= 1'b1;
			written <= '0;
			cmd.finished <= 1'b0;
		end else begin
			if (pop) written <= written + 1'b1;
			if (active && written == cmd.count) begin
				active <= 1'b0;
				cmd.finished <= 1'b1; // controller closes the job next edge
			end
		end
	end

endmodule

//--- filelist.f
common/dma_pkg.sv
common/avmm_if.sv
common/dma_cmd_if.sv
dma/dma_fifo.sv
dma/dma_ctrl.sv
dma/dma_read_master.sv
dma/dma_write_master.sv
rtl/mmio_bridge.sv
rtl/bank_switch.sv
rtl/afu.sv
testbench/tb_avmm_mem.sv
testbench/tb_afu.sv

//--- rtl/afu.sv
/* copy engine between two local banks, everything on clk
   bank ports are word addressed, single word, no bursts */
`timescale 1ns/1ns

module afu #(
	parameter int mem_addr_width = 12,
	parameter int fifo_depth = 8
) (
	input logic clk,
	input logic reset,
	// mmio stream
	input dma_pkg::t_mmio_req mmio_req_data,
	input logic mmio_req_valid,
	output logic mmio_req_ready,
	output logic [dma_pkg::mmio_data_width-1:0] mmio_rsp_data,
	output logic mmio_rsp_valid,
	input logic mmio_rsp_ready,
	// bank a
	output logic [mem_addr_width-1:0] mem_a_address,
	output logic mem_a_read,
	output logic mem_a_write,
	output dma_pkg::t_word mem_a_writedata,
	input logic mem_a_waitrequest,
	input dma_pkg::t_word mem_a_readdata,
	input logic mem_a_readdatavalid,
	// bank b
	output logic [mem_addr_width-1:0] mem_b_address,
	output logic mem_b_read,
	output logic mem_b_write,
	output dma_pkg::t_word mem_b_writedata,
	input logic mem_b_waitrequest,
	input dma_pkg::t_word mem_b_readdata,
	input logic mem_b_readdatavalid
);
	import dma_pkg::*;

	logic reg_wr;
	logic reg_rd;
	logic [mmio_addr_width-1:0] reg_addr;
	logic [mmio_data_width-1:0] reg_wdata;
	logic [mmio_data_width-1:0] reg_rdata;
	logic dir;
	logic push;
	logic pop;
	logic fifo_empty;
	t_word push_data;
	t_word pop_data;
	logic [$clog2(fifo_depth+1)-1:0] fifo_count;

	avmm_if #(.mem_addr_width(mem_addr_width)) rd_mem ();
	avmm_if #(.mem_addr_width(mem_addr_width)) wr_mem ();
	avmm_if #(.mem_addr_width(mem_addr_width)) bank_a ();
	avmm_if #(.mem_addr_width(mem_addr_width)) bank_b ();
	dma_cmd_if #(.mem_addr_width(mem_addr_width)) rd_cmd ();
	dma_cmd_if #(.mem_addr_width(mem_addr_width)) wr_cmd ();

	// ********************
	// host side
	mmio_bridge mmio_bridge_i (
		.clk(clk), .reset(reset),
		.req_data(mmio_req_data), .req_valid(mmio_req_valid), .req_ready(mmio_req_ready),
		.rsp_data(mmio_rsp_data), .rsp_valid(mmio_rsp_valid), .rsp_ready(mmio_rsp_ready),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
	);

	dma_ctrl #(.mem_addr_width(mem_addr_width)) dma_ctrl_i (
		.clk(clk), .reset(reset),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
		.dir(dir), .rd_cmd(rd_cmd.ctrl), .wr_cmd(wr_cmd.ctrl)
	);

	// ********************
	// datapath
	dma_read_master #(
		.mem_addr_width(mem_addr_width), .fifo_depth(fifo_depth)
	) dma_read_master_i (
		.clk(clk), .reset(reset), .fifo_count(fifo_count),
		.push(push), .push_data(push_data), .cmd(rd_cmd.engine), .mem(rd_mem.master)
	);

	dma_fifo #(.t_payload(t_word), .depth(fifo_depth)) word_fifo (
		.clk(clk), .reset(reset), .push(push), .push_data(push_data),
		.pop(pop), .pop_data(pop_data), .empty(fifo_empty), .full(), .count(fifo_count)
	);

	dma_write_master #(.mem_addr_width(mem_addr_width)) dma_write_master_i (
		.clk(clk), .reset(reset), .fifo_empty(fifo_empty), .pop_data(pop_data),
		.pop(pop), .cmd(wr_cmd.engine), .mem(wr_mem.master)
	);

	bank_switch bank_switch_i (
		.dir(dir), .rd_mem(rd_mem.slave), .wr_mem(wr_mem.slave),
		.bank_a(bank_a.master), .bank_b(bank_b.master)
	);

	// bank pins
	assign mem_a_address = bank_a.address;
	assign mem_a_read = bank_a.read;
	assign mem_a_write = bank_a.write;
	assign mem_a_writedata = bank_a.writedata;
	assign bank_a.waitrequest = mem_a_waitrequest;
	assign bank_a.readdata = mem_a_readdata;
	assign bank_a.readdatavalid = mem_a_readdatavalid;

	assign mem_b_address = bank_b.address;
	assign mem_b_read = bank_b.read;
	assign mem_b_write = bank_b.write;
	assign mem_b_writedata = bank_b.writedata;
	assign bank_b.waitrequest = mem_b_waitrequest;
	assign bank_b.readdata = mem_b_readdata;
	assign bank_b.readdatavalid = mem_b_readdatavalid;

endmodule

//--- rtl/bank_switch.sv
/* dir 0 reads bank a and writes bank b, dir 1 the reverse
   dir must not change while either master has a command up */
`timescale 1ns/1ns

module bank_switch (
	input logic dir,
	avmm_if.slave rd_mem,
	avmm_if.slave wr_mem,
	avmm_if.master bank_a,
	avmm_if.master bank_b
);

	// ********************
	// commands out
	assign bank_a.read = dir ? 1'b0 : rd_mem.read; // a is source when dir 0
	assign bank_a.write = dir ? wr_mem.write : 1'b0;
	assign bank_a.address = dir ? wr_mem.address : rd_mem.address;
	assign bank_a.writedata = wr_mem.writedata; // only write side carries data

	assign bank_b.read = dir ? rd_mem.read : 1'b0;
	assign bank_b.write = dir ? 1'b0 : wr_mem.write;
	assign bank_b.address = dir ? rd_mem.address : wr_mem.address;
	assign bank_b.writedata = wr_mem.writedata;

	// ********************
	// responses back
	assign rd_mem.waitrequest = dir ? bank_b.waitrequest : bank_a.waitrequest;
	assign rd_mem.readdata = dir ? bank_b.readdata : bank_a.readdata;
	assign rd_mem.readdatavalid = dir ? bank_b.readdatavalid : bank_a.readdatavalid;

	assign wr_mem.waitrequest = dir ? bank_a.waitrequest : bank_b.waitrequest;
	// write master never reads
	assign wr_mem.readdata = '0;
	assign wr_mem.readdatavalid = 1'b0;

endmodule

//--- rtl/mmio_bridge.sv
/* one register access per request, a single read outstanding at a time
   requests with neither flag set are dropped quietly */
`timescale 1ns/1ns

module mmio_bridge (
	input logic clk,
	input logic reset,
	input dma_pkg::t_mmio_req req_data,
	input logic req_valid,
	output logic req_ready,
	output logic [dma_pkg::mmio_data_width-1:0] rsp_data,
	output logic rsp_valid,
	input logic rsp_ready,
	output logic reg_wr,
	output logic reg_rd,
	output logic [dma_pkg::mmio_addr_width-1:0] reg_addr,
	output logic [dma_pkg::mmio_data_width-1:0] reg_wdata,
	input logic [dma_pkg::mmio_data_width-1:0] reg_rdata
);
	import dma_pkg::*;

	t_mmio_req head; // oldest buffered request
	logic buf_empty;
	logic buf_full;
	logic buf_pop;

	// stall the host while a response waits
	assign req_ready = !buf_full && !rsp_valid;

	dma_fifo #(
		.t_payload(t_mmio_req),
		.depth(2)
	) req_buf (
		.clk(clk),
		.reset(reset),
		.push(req_valid && req_ready),
		.push_data(req_data),
		.pop(buf_pop),
		.pop_data(head),
		.empty(buf_empty),
		.full(buf_full),
		.count()
	);

	// ********************
	// register access
	assign buf_pop = !buf_empty && !rsp_valid; // hold head behind a pending read
	assign reg_wr = buf_pop && head.wr;
	assign reg_rd = buf_pop && head.rd;
	assign reg_addr = head.addr;
	assign reg_wdata = head.data;

	always_ff @(posedge clk) begin
		if (reset)
			rsp_valid <= 1'b0;
		else if (reg_rd)
			rsp_valid <= 1'b1; // valid from next cycle
		else if (rsp_ready)
			rsp_valid <= 1'b0; // taken
	end

	always_ff @(posedge clk)
		if (reg_rd) rsp_data <= reg_rdata; // held until taken

	// host must pick one of read or write
	a_req_one_kind : assert property (@(posedge clk) disable iff (reset)
		req_valid |-> !(req_data.wr && req_data.rd));

endmodule

//--- testbench/tb_afu.sv
/* runs register read-back and copy jobs on afu, compares both banks with a model
   banks are filled through hierarchy while reset is held */
`timescale 1ns/1ns

module tb_afu;
	import dma_pkg::*;

	localparam int mem_addr_width = 12;
	localparam int bank_words = 2**mem_addr_width;
	localparam logic [63:0] src_mask = 64'(bank_words - 1);
	localparam logic [63:0] len_mask = 64'(2 * bank_words - 1); // one extra bit

	logic clk = 1'b0;
	logic reset;
	t_mmio_req mmio_req_data;
	logic mmio_req_valid;
	logic mmio_req_ready;
	logic [63:0] mmio_rsp_data;
	logic mmio_rsp_valid;
	logic mmio_rsp_ready;
	logic [mem_addr_width-1:0] mem_a_address;
	logic mem_a_read;
	logic mem_a_write;
	t_word mem_a_writedata;
	logic mem_a_waitrequest;
	t_word mem_a_readdata;
	logic mem_a_readdatavalid;
	logic [mem_addr_width-1:0] mem_b_address;
	logic mem_b_read;
	logic mem_b_write;
	t_word mem_b_writedata;
	logic mem_b_waitrequest;
	t_word mem_b_readdata;
	logic mem_b_readdatavalid;

	t_word model_a [bank_words]; // expected bank contents
	t_word model_b [bank_words];
	int errors = 0;
	int cycles = 0;
	int limit = 100; // grows with each access and each job
	bit rsp_stall = 1'b0; // random low mmio_rsp_ready
	logic [63:0] value;
	int len;

	afu #(.mem_addr_width(mem_addr_width), .fifo_depth(8)) afu_i (.*);

	tb_avmm_mem #(.addr_width(mem_addr_width)) bank_a_mem (
		.clk(clk), .reset(reset), .address(mem_a_address), .read(mem_a_read),
		.write(mem_a_write), .writedata(mem_a_writedata), .waitrequest(mem_a_waitrequest),
		.readdata(mem_a_readdata), .readdatavalid(mem_a_readdatavalid)
	);

	tb_avmm_mem #(.addr_width(mem_addr_width)) bank_b_mem (
		.clk(clk), .reset(reset), .address(mem_b_address), .read(mem_b_read),
		.write(mem_b_write), .writedata(mem_b_writedata), .waitrequest(mem_b_waitrequest),
		.readdata(mem_b_readdata), .readdatavalid(mem_b_readdatavalid)
	);

	always #50 clk = !clk;

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout, DUT made no progress within %0d cycles", cycles);
			$display("errors: %0d", errors);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	// ********************
	// mmio stream, all tasks start and end on a falling edge
	task automatic send_request(input bit wr, input bit rd, input logic [17:0] addr,
			input logic [63:0] data);
		mmio_req_data = '{wr: wr, rd: rd, addr: addr, data: data};
		mmio_req_valid = 1'b1;
		while (!mmio_req_ready) @(negedge clk); // ready is stable here
		@(negedge clk); // taken on the edge between
		mmio_req_valid = 1'b0;
	endtask

	task automatic mmio_write(input logic [17:0] addr, input logic [63:0] data);
		limit += 200;
		send_request(1'b1, 1'b0, addr, data);
	endtask

	task automatic mmio_read(input logic [17:0] addr, output logic [63:0] data);
		bit taken;
		taken = 1'b0;
		send_request(1'b0, 1'b1, addr, '0);
		while (!taken) begin
			mmio_rsp_ready = rsp_stall ? 1'($urandom_range(0, 1)) : 1'b1;
			taken = mmio_rsp_valid && mmio_rsp_ready;
			if (taken) data = mmio_rsp_data;
			@(negedge clk);
		end
		mmio_rsp_ready = 1'b1;
		assert (!mmio_rsp_valid) else begin
			errors++;
			$display("response stayed valid after it was taken, duplicate response");
		end
	endtask

	task automatic read_check(input logic [17:0] addr, input logic [63:0] exp, input string name);
		logic [63:0] data;
		limit += 200;
		mmio_read(addr, data);
		check_value(name, data, exp);
	endtask

	// ********************
	// jobs and model
	task automatic run_job(input int src, input int dst, input int len, input bit dir,
			input bit restart);
		logic [63:0] status;
		limit += 40 * len + 200; // polling rides on this
		mmio_write(reg_src, src);
		mmio_write(reg_dst, dst);
		mmio_write(reg_len, len);
		mmio_write(reg_ctrl, {dir, 1'b1});
		if (restart) mmio_write(reg_ctrl, {!dir, 1'b1}); // lands while busy
		mmio_read(reg_status, status);
		if (restart) check_value("mmio_rsp_data status after start", status & 3, 64'h1);
		while (!status[status_done_bit]) mmio_read(reg_status, status);
		check_value("mmio_rsp_data status at end", status, 64'h2); // done, not busy
		for (int i = 0; i < len; i++) begin
			if (dir) model_a[(dst + i) % bank_words] = model_b[(src + i) % bank_words];
			else model_b[(dst + i) % bank_words] = model_a[(src + i) % bank_words];
		end
	endtask

	task automatic compare_banks();
		for (int i = 0; i < bank_words; i++) begin
			assert (bank_a_mem.mem[i] === model_a[i]) else begin
				errors++;
				$display("Fail bank_a mem[%h]: got %h expected %h", i, bank_a_mem.mem[i], model_a[i]);
			end
			assert (bank_b_mem.mem[i] === model_b[i]) else begin
				errors++;
				$display("Fail bank_b mem[%h]: got %h expected %h", i, bank_b_mem.mem[i], model_b[i]);
			end
		end
	endtask

	initial begin
		void'($urandom(6));
		reset = 1'b1;
		mmio_req_data = '0;
		mmio_req_valid = 1'b0;
		mmio_rsp_ready = 1'b1;
		for (int i = 0; i < bank_words; i++) begin
			model_a[i] = {$urandom, $urandom};
			model_b[i] = {$urandom, $urandom};
			bank_a_mem.mem[i] = model_a[i];
			bank_b_mem.mem[i] = model_b[i];
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// ********************
		// register read-back
		read_check(reg_status, 64'h0, "mmio_rsp_data status after reset");
		repeat (3) begin
			value = {$urandom, $urandom};
			mmio_write(reg_src, value);
			read_check(reg_src, value & src_mask, "mmio_rsp_data reg_src");
			value = {$urandom, $urandom};
			mmio_write(reg_dst, value);
			read_check(reg_dst, value & src_mask, "mmio_rsp_data reg_dst");
			value = {$urandom, $urandom};
			mmio_write(reg_len, value);
			read_check(reg_len, value & len_mask, "mmio_rsp_data reg_len");
		end
		read_check(18'h04, 64'h0, "mmio_rsp_data unmapped 0x04"); // misaligned
		read_check(18'h28, 64'h0, "mmio_rsp_data unmapped 0x28");
		read_check(18'h28 + 18'($urandom_range(0, 4000)) * 8, 64'h0, "mmio_rsp_data unmapped");

		// ********************
		// copies, a to b then b to a
		run_job($urandom_range(0, bank_words - 1), $urandom_range(0, bank_words - 1),
			$urandom_range(1, 64), 1'b0, 1'b0);
		compare_banks();
		run_job($urandom_range(0, bank_words - 1), $urandom_range(0, bank_words - 1),
			$urandom_range(1, 64), 1'b1, 1'b0);
		compare_banks();

		// host back-pressure on responses as well
		rsp_stall = 1'b1;
		repeat (3) begin
			len = $urandom_range(1, 48);
			run_job($urandom_range(0, bank_words - 1), $urandom_range(0, bank_words - 1),
				len, 1'($urandom_range(0, 1)), 1'b0);
			compare_banks();
			read_check(reg_len, 64'(len), "mmio_rsp_data reg_len after job");
		end
		rsp_stall = 1'b0;

		// second start while busy, then an empty job
		run_job($urandom_range(0, bank_words - 1), $urandom_range(0, bank_words - 1),
			$urandom_range(16, 48), 1'b0, 1'b1);
		compare_banks();
		run_job($urandom_range(0, bank_words - 1), $urandom_range(0, bank_words - 1),
			0, 1'b1, 1'b0);
		compare_banks();

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- testbench/tb_avmm_mem.sv
/* word memory bank with random waitrequest and in-order read data after 1 to 4 cycles
   contents are loaded and inspected by the testbench through the mem array */
`timescale 1ns/1ns

module tb_avmm_mem #(
	parameter int addr_width = 12
) (
	input logic clk,
	input logic reset,
	input logic [addr_width-1:0] address,
	input logic read,
	input logic write,
	input dma_pkg::t_word writedata,
	output logic waitrequest,
	output dma_pkg::t_word readdata,
	output logic readdatavalid
);
	import dma_pkg::*;

	t_word mem [2**addr_width]; // bank contents
	t_word rd_data_q [$]; // accepted reads, oldest first
	int rd_due_q [$]; // cycle each read may return
	int cyc;
	int last_due;
	int due;

	initial begin
		waitrequest = 1'b0;
		readdata = '0;
		readdatavalid = 1'b0;
		cyc = 0;
		last_due = 0;
	end

	// ********************
	// command side, sampled on the rising edge
	always @(posedge clk) begin
		if (reset) begin
			cyc = 0;
			last_due = 0;
			rd_data_q.delete();
			rd_due_q.delete();
		end else begin
			cyc++;
			if (read && !waitrequest) begin
				due = cyc + $urandom_range(1, 4);
				if (due <= last_due) due = last_due + 1; // keep return order
				last_due = due;
				rd_data_q.push_back(mem[address]);
				rd_due_q.push_back(due);
			end
			if (write && !waitrequest) mem[address] = writedata;
		end
	end

	// response side, driven on the falling edge
	always @(negedge clk) begin
		readdatavalid <= 1'b0;
		waitrequest <= reset ? 1'b0 : ($urandom_range(0, 3) == 0); // stall about 1 in 4
		if (!reset && rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
			readdatavalid <= 1'b1;
			readdata <= rd_data_q.pop_front();
			void'(rd_due_q.pop_front());
		end
	end

endmodule
